// ==== fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Widths of the fetch datapath.
`define FETCH_ADDR_W    32           // the pc is a full 32-bit byte address.
`define FETCH_INSTR_W   32           // only uncompressed instructions are fetched.

// Queue sizes, given as log2 of the entry count.
`define REQ_Q_DEPTH_W   2            // four addresses wait ahead of memory.
`define RESP_Q_DEPTH_W  3            // eight packets wait for decode.

// Memory side flow control.
`define MEM_CREDITS     4            // memory owns this many request slots after reset.

// Fetch starts here when reset is released.
`define FETCH_RESET_PC  32'h8000_0000 // boot address of the core.

`endif

// ==== fetch_pkg.sv ====
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

   // a fetch request as it waits in the request queue and goes to memory.
   typedef struct packed {
      logic                      epoch; // epoch that was current when the pc was made.
      logic [`FETCH_ADDR_W-1:0]  pc;    // byte address of the instruction.
   } fetch_req_t;

   // a memory response, which echoes the request it answers.
   typedef struct packed {
      logic                      epoch; // copied from the request.
      logic [`FETCH_ADDR_W-1:0]  pc;    // copied from the request.
      logic [`FETCH_INSTR_W-1:0] instr; // the instruction word that was read.
   } fetch_resp_t;

   // Packet handed to the decode stage.
   typedef struct packed {
      logic [`FETCH_ADDR_W-1:0]  pc;        // address of the instruction.
      logic [`FETCH_INSTR_W-1:0] instr;     // raw instruction word.
      logic                      is_branch; // set for branch, jal and jalr.
   } fetch_pkt_t;

endpackage

`default_nettype wire

// ==== reg_file_1w1r.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file_1w1r #(
   parameter type payload_t = logic [31:0], // type of one stored word.
   parameter int  addr_w    = 2             // address width, giving 2**addr_w words.
) (
   input  wire              clk,
   input  wire              we,    // write strobe.
   input  wire [addr_w-1:0] waddr, // write address.
   input  wire payload_t    wdata, // write data.
   input  wire              re,    // read strobe, loads the read register.
   input  wire [addr_w-1:0] raddr, // read address.
   output payload_t         rdata  // registered read data.
);

   localparam int depth = 2 ** addr_w; // number of words in the array.

   payload_t mem [depth]; // storage array.

   // the write port is a plain synchronous write.
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata; // store the word at the write address.
      end
   end

   // The read register only moves when re is high.
   // The FIFO uses this to prefetch the next head while it pops the current one.
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[raddr]; // old contents are read if raddr is written now.
      end
   end

endmodule

`default_nettype wire

// ==== fifo_fwft.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_fwft #(
   parameter type payload_t   = logic [31:0], // type of one queue entry.
   parameter int  depth_width = 2             // log2 of the number of entries.
) (
   input  wire           clk,
   input  wire           arst_n,
   input  wire           flush, // empties the queue at the next edge.
   input  wire           push,  // writes din when ready is high.
   input  wire payload_t din,
   output logic          ready, // low only while the queue is full.
   input  wire           pop,   // drops the head when valid is high.
   output payload_t      dout,  // head of the queue, valid in the same cycle.
   output logic          valid  // high while the queue holds an entry.
);

   localparam logic [depth_width:0] ptr_one = 1; // pointer increment.

   logic [depth_width:0] w_ptr, r_ptr;         // one extra bit tells full from empty.
   logic [depth_width:0] w_ptr_nxt, r_ptr_nxt; // pointers after one step.
   logic                 wr_en, rd_en;         // accepted push and pop.
   logic                 state_r;              // head is held in dat_r.
   logic                 fwft_nxt, clr_state;  // set and clear of state_r.
   payload_t             dat_r;                // word pushed into an empty queue.
   payload_t             din_r;                // word written while it was prefetched.
   payload_t             rf_dout;              // prefetched head from the array.
   logic                 rf_conflict;          // prefetch address is being written.
   logic                 bypass_r;             // din_r replaces the array output.

   assign ready = (w_ptr[depth_width] == r_ptr[depth_width]) |
                  (w_ptr[depth_width-1:0] != r_ptr[depth_width-1:0]); // not full.
   assign valid = (w_ptr != r_ptr); // not empty.

   assign wr_en     = push & ready; // a push into a full queue is ignored.
   assign rd_en     = pop & valid;  // a pop of an empty queue is ignored.
   assign w_ptr_nxt = w_ptr + ptr_one;
   assign r_ptr_nxt = r_ptr + ptr_one;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         w_ptr <= '0;
         r_ptr <= '0;
      end else if (flush) begin
         w_ptr <= '0; // flush wins over a push in the same cycle.
         r_ptr <= '0;
      end else begin
         if (wr_en) w_ptr <= w_ptr_nxt;
         if (rd_en) r_ptr <= r_ptr_nxt;
      end
   end

   assign fwft_nxt  = ~state_r & ~valid & wr_en; // first word into an empty queue.
   assign clr_state = state_r & rd_en;           // that word leaves the queue.

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_r <= 1'b0;
      end else if (flush) begin
         state_r <= 1'b0;
      end else if (fwft_nxt) begin
         state_r <= 1'b1; // head shows at dout right after the push edge.
      end else if (clr_state) begin
         state_r <= 1'b0; // from now on the head comes from the array.
      end
   end

   always_ff @(posedge clk) begin
      if (fwft_nxt) dat_r <= din; // capture the first word directly.
      if (rd_en) din_r <= din;    // kept in case the prefetch collides with this write.
   end

   reg_file_1w1r #(
      .payload_t (payload_t),
      .addr_w    (depth_width)
   ) u_rf (
      .clk   (clk),
      .we    (wr_en),
      .waddr (w_ptr[depth_width-1:0]),
      .wdata (din),
      .re    (rd_en),
      .raddr (r_ptr_nxt[depth_width-1:0]), // prefetch the entry behind the head.
      .rdata (rf_dout)
   );

   assign rf_conflict = wr_en & rd_en &
                        (w_ptr[depth_width-1:0] == r_ptr_nxt[depth_width-1:0]);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bypass_r <= 1'b0;
      end else if (rd_en) begin
         bypass_r <= rf_conflict; // the array read returned stale data when this is set.
      end
   end

   assign dout = state_r ? dat_r : (bypass_r ? din_r : rf_dout);

endmodule

`default_nettype wire

// ==== pc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module pc_sequencer
   import fetch_pkg::*;
(
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     redirect_valid, // load a new pc this cycle.
   input  wire [`FETCH_ADDR_W-1:0] redirect_pc,    // target of the redirect.
   input  wire                     req_ready,      // request queue has room.
   output logic                    req_push,       // push req into the queue.
   output fetch_req_t              req,            // current pc with its epoch.
   output logic                    epoch           // epoch that predecode compares against.
);

   localparam logic [`FETCH_ADDR_W-1:0] pc_step = 4; // one uncompressed instruction.

   logic [`FETCH_ADDR_W-1:0] pc_r;    // next address to fetch.
   logic                     epoch_r; // flips on every redirect.

   // a redirect cycle pushes nothing, because pc_r still holds the old path.
   assign req_push = req_ready & ~redirect_valid;

   assign req   = '{epoch: epoch_r, pc: pc_r}; // the request carries its epoch along.
   assign epoch = epoch_r;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_r    <= `FETCH_RESET_PC; // fetch starts at the boot address.
         epoch_r <= 1'b0;
      end else if (redirect_valid) begin
         pc_r    <= redirect_pc; // the next push carries the redirect target.
         epoch_r <= ~epoch_r;    // responses still in flight become stale.
      end else if (req_push) begin
         pc_r    <= pc_r + pc_step; // sequential fetch.
      end
   end

endmodule

`default_nettype wire

// ==== credit_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module credit_sender
   import fetch_pkg::*;
(
   input  wire        clk,
   input  wire        arst_n,
   input  wire        req_valid,        // request queue has a head.
   input  wire        fetch_req_t req,  // head of the request queue.
   output logic       req_pop,          // head was sent to memory.
   output logic       mem_req_valid,    // memory must take the request this cycle.
   output fetch_req_t mem_req,          // request to instruction memory.
   input  wire        mem_credit_return // one slot freed in the memory request buffer.
);

   localparam int                credit_w    = $clog2(`MEM_CREDITS + 1); // fits the full count.
   localparam logic [credit_w-1:0] credit_init = credit_w'(`MEM_CREDITS);
   localparam logic [credit_w-1:0] credit_one  = 1;

   logic [credit_w-1:0] credit_cnt; // free slots in the memory request buffer.
   logic                send;       // a request goes out this cycle.

   // Memory never refuses, so the only thing that can hold a request back
   // is an empty credit count.
   assign send = req_valid & (credit_cnt != '0);

   assign req_pop       = send; // pop and issue happen together.
   assign mem_req_valid = send;
   assign mem_req       = req;  // the queue head goes straight to memory.

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credit_cnt <= credit_init; // memory starts with every slot free.
      end else begin
         case ({send, mem_credit_return})
            2'b10:   credit_cnt <= credit_cnt - credit_one; // a slot was taken.
            2'b01:   credit_cnt <= credit_cnt + credit_one; // a slot came back.
            default: credit_cnt <= credit_cnt;              // both or neither cancel out.
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecode
   import fetch_pkg::*;
(
   input  wire         mem_resp_valid, // memory presents a response.
   input  wire         fetch_resp_t mem_resp,
   input  wire         epoch,          // current epoch from the sequencer.
   output logic        resp_push,      // push pkt into the response queue.
   output fetch_pkt_t  pkt             // packet for the decode stage.
);

   // RV32I opcodes that change control flow.
   localparam logic [6:0] op_branch = 7'b1100011; // conditional branches.
   localparam logic [6:0] op_jal    = 7'b1101111; // jump and link.
   localparam logic [6:0] op_jalr   = 7'b1100111; // jump and link register.

   logic [6:0] opcode;      // major opcode field of the instruction.
   logic       epoch_match; // the response belongs to the current path.
   logic       is_ctrl;     // the instruction is a control transfer.

   assign opcode      = mem_resp.instr[6:0];
   assign epoch_match = (mem_resp.epoch == epoch);

   // A stale response is simply not pushed.
   // Memory still sees ready and retires it as if it had been taken.
   assign resp_push = mem_resp_valid & epoch_match;

   always_comb begin
      case (opcode)
         op_branch: is_ctrl = 1'b1;
         op_jal:    is_ctrl = 1'b1;
         op_jalr:   is_ctrl = 1'b1;
         default:   is_ctrl = 1'b0; // everything else falls through.
      endcase
   end

   always_comb begin
      pkt.pc        = mem_resp.pc;    // address passes through unchanged.
      pkt.instr     = mem_resp.instr; // so does the instruction word.
      pkt.is_branch = is_ctrl;
   end

endmodule

`default_nettype wire

// ==== fetch_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit_top
   import fetch_pkg::*;
(
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     redirect_valid,    // new pc from the back end.
   input  wire [`FETCH_ADDR_W-1:0] redirect_pc,
   output logic                    mem_req_valid,     // request to instruction memory.
   output fetch_req_t              mem_req,
   input  wire                     mem_credit_return, // one credit back from memory.
   input  wire                     mem_resp_valid,    // response from instruction memory.
   input  wire                     fetch_resp_t mem_resp,
   output logic                    mem_resp_ready,    // response queue can take a packet.
   output logic                    dec_valid,         // decode has a packet to take.
   output fetch_pkt_t              dec_pkt,
   input  wire                     dec_pop            // decode consumed dec_pkt.
);

   logic       req_push;    // sequencer pushes a new pc.
   fetch_req_t seq_req;     // pc and epoch from the sequencer.
   logic       req_ready;   // request queue has room.
   logic       req_q_valid; // request queue has a head.
   fetch_req_t req_q_dout;  // head of the request queue.
   logic       req_pop;     // head was issued to memory.
   logic       epoch;       // current epoch.
   logic       resp_push;   // current-epoch response.
   fetch_pkt_t resp_pkt;    // predecoded packet.

   pc_sequencer u_pc_sequencer (
      .clk            (clk),
      .arst_n         (arst_n),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .req_ready      (req_ready),
      .req_push       (req_push),
      .req            (seq_req),
      .epoch          (epoch)
   );

   // addresses wait here until memory has a free slot.
   fifo_fwft #(
      .payload_t   (fetch_req_t),
      .depth_width (`REQ_Q_DEPTH_W)
   ) req_q (
      .clk    (clk),
      .arst_n (arst_n),
      .flush  (redirect_valid), // requests from the old path are thrown away.
      .push   (req_push),
      .din    (seq_req),
      .ready  (req_ready),
      .pop    (req_pop),
      .dout   (req_q_dout),
      .valid  (req_q_valid)
   );

   credit_sender u_credit_sender (
      .clk               (clk),
      .arst_n            (arst_n),
      .req_valid         (req_q_valid),
      .req               (req_q_dout),
      .req_pop           (req_pop),
      .mem_req_valid     (mem_req_valid),
      .mem_req           (mem_req),
      .mem_credit_return (mem_credit_return)
   );

   predecode u_predecode (
      .mem_resp_valid (mem_resp_valid),
      .mem_resp       (mem_resp),
      .epoch          (epoch),
      .resp_push      (resp_push),
      .pkt            (resp_pkt)
   );

   // The queue's ready doubles as mem_resp_ready, so memory holds a response while it is full.
   fifo_fwft #(
      .payload_t   (fetch_pkt_t),
      .depth_width (`RESP_Q_DEPTH_W)
   ) resp_q (
      .clk    (clk),
      .arst_n (arst_n),
      .flush  (redirect_valid), // decode never sees packets from the old path.
      .push   (resp_push),
      .din    (resp_pkt),
      .ready  (mem_resp_ready),
      .pop    (dec_pop),
      .dout   (dec_pkt),
      .valid  (dec_valid)
   );

endmodule

`default_nettype wire

// ==== tb_fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch_unit
   import fetch_pkg::*;
();

   localparam int max_cycles     = 3000;                   // the six tests need about 600 cycles.
   localparam int resp_q_entries = 2 ** `RESP_Q_DEPTH_W;   // packets the response queue can hold.

   logic                     clk               = 1'b0;
   logic                     arst_n            = 1'b0;     // reset is asserted from time zero.
   logic                     redirect_valid    = 1'b0;
   logic [`FETCH_ADDR_W-1:0] redirect_pc       = '0;
   logic                     mem_credit_return = 1'b0;
   logic                     mem_resp_valid    = 1'b0;
   fetch_resp_t              mem_resp          = '0;
   logic                     dec_pop           = 1'b0;
   logic                     mem_req_valid, mem_resp_ready, dec_valid;
   fetch_req_t               mem_req;
   fetch_pkt_t               dec_pkt;

   integer seed         = 32'h2227_fb9e;  // one seed feeds every random draw.
   string  cur_test     = "none";
   int     err_cnt      = 0;
   int     cycle_cnt    = 0;
   int     resp_granted = 0;              // responses the memory may send so far.
   int     pop_mode     = 0;              // 0 holds decode, 1 pops always, 2 pops at random.
   logic   delay_en     = 1'b0;           // random gaps between memory responses.
   int     issued_cnt   = 0;
   int     xfer_cnt     = 0;              // responses retired by memory, stale ones too.
   int     popped_cnt   = 0;              // packets that decode took from the DUT.
   int     stale_cnt    = 0;
   int     branch_cnt   = 0;
   int     exp_left     = 0;              // predicted packets still waiting for decode.

   fetch_req_t               pending[$];  // issued requests that memory has not answered.
   fetch_pkt_t               exp_q[$];    // predicted contents of the response queue.
   logic [`FETCH_ADDR_W-1:0] exp_req_pc;
   logic                     tb_epoch;
   int                       credits, resp_sent, gap;

   fetch_unit_top dut (.*);

   always #10 clk = ~clk; // 20 ns period.

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("Test failures found");
         $finish;
      end
   end

   function automatic logic is_ctrl_op(input logic [6:0] op);
      return (op == 7'b1100011) || (op == 7'b1101111) || (op == 7'b1100111); // branch, jal, jalr.
   endfunction

   function automatic logic [6:0] pick_opcode(input logic [2:0] sel);
      case (sel)
         3'd0:    return 7'b1100011; // conditional branch.
         3'd1:    return 7'b1101111; // jal.
         3'd2:    return 7'b1100111; // jalr.
         3'd3:    return 7'b0110011; // register alu op.
         3'd4:    return 7'b0000011; // load.
         default: return 7'b0010011; // immediate alu op.
      endcase
   endfunction

   task automatic check_eq(input string what, input logic [95:0] expect_v,
                           input logic [95:0] actual_v);
      assert (expect_v === actual_v) else begin
         err_cnt++;
         $display("mismatch %s %s: expected %h actual %h", cur_test, what, expect_v, actual_v);
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      assert (cond) else begin
         err_cnt++;
         $display("error in %s: %s", cur_test, msg);
      end
   endtask

   // scoreboard, memory model and decode stage, all stepped on the rising edge.
   always @(posedge clk) begin
      fetch_pkt_t  pkt;
      logic [31:0] rnd, pop_rnd;
      logic        xfer;
      pop_rnd = $random(seed);
      if (!arst_n) begin
         pending.delete();
         exp_q.delete();
         exp_req_pc = `FETCH_RESET_PC; // the first request must carry the boot address.
         tb_epoch   = 1'b0;
         credits    = `MEM_CREDITS;
         resp_sent  = 0;
         gap        = 0;
         mem_resp_valid    <= 1'b0;
         mem_credit_return <= 1'b0;
         dec_pop           <= 1'b0;
      end else begin
         check_eq("dec_valid", 96'(exp_q.size() != 0), 96'(dec_valid));
         if (dec_valid && exp_q.size() != 0) check_eq("dec_pkt", 96'(exp_q[0]), 96'(dec_pkt));
         check_eq("mem_resp_ready", 96'(exp_q.size() < resp_q_entries), 96'(mem_resp_ready));
         if (dec_pop && dec_valid) begin
            popped_cnt <= popped_cnt + 1; // decode took the head.
            if (exp_q.size() != 0) begin
               pkt = exp_q.pop_front();
               if (pkt.is_branch) branch_cnt <= branch_cnt + 1;
            end
         end
         xfer = mem_resp_valid && mem_resp_ready; // a response leaves memory.
         if (xfer) begin
            void'(pending.pop_front());
            xfer_cnt <= xfer_cnt + 1;
            if (mem_resp.epoch != tb_epoch) begin
               stale_cnt <= stale_cnt + 1; // predecode must drop it.
            end else if (!redirect_valid) begin
               pkt.pc        = mem_resp.pc;
               pkt.instr     = mem_resp.instr;
               pkt.is_branch = is_ctrl_op(mem_resp.instr[6:0]);
               exp_q.push_back(pkt);
            end
         end
         if (mem_req_valid) begin
            check_true(credits > 0, "a request was issued while no credit was left");
            check_eq("mem_req.pc", 96'(exp_req_pc), 96'(mem_req.pc));
            check_eq("mem_req.epoch", 96'(tb_epoch), 96'(mem_req.epoch));
            pending.push_back(mem_req);
            exp_req_pc = exp_req_pc + 32'd4;
            credits--;
            issued_cnt <= issued_cnt + 1;
         end
         if (mem_credit_return) credits++;
         if (redirect_valid) begin
            exp_q.delete();           // both queues are flushed at this edge.
            exp_req_pc = redirect_pc;
            tb_epoch   = ~tb_epoch;
         end
         mem_credit_return <= xfer;   // every answer frees one request slot.
         if (xfer || !mem_resp_valid) begin
            mem_resp_valid <= 1'b0;
            if (gap > 0) begin
               gap--;
            end else if (pending.size() != 0 && resp_sent < resp_granted) begin
               rnd = $random(seed);
               mem_resp <= '{epoch: pending[0].epoch, pc: pending[0].pc,
                             instr: {rnd[31:7], pick_opcode(rnd[2:0])}};
               mem_resp_valid <= 1'b1;
               resp_sent++;
               gap = delay_en ? int'(rnd[4:3]) : 0;
            end
         end
         dec_pop  <= (pop_mode == 1 || (pop_mode == 2 && pop_rnd[0])) && exp_q.size() != 0;
         exp_left <= exp_q.size();
      end
   end

   task automatic grant_responses(input int n);
      resp_granted <= resp_granted + n;
      @(posedge clk);
   endtask

   task automatic wait_drained();
      while (xfer_cnt < resp_granted || exp_left != 0) @(posedge clk);
   endtask

   task automatic test_reset();
      cur_test <= "test_reset";
      repeat (4) begin
         @(posedge clk);
         check_true(!dec_valid && !mem_req_valid, "dec_valid or mem_req_valid was high in reset");
      end
      arst_n <= 1'b1;
      while (issued_cnt < `MEM_CREDITS) @(posedge clk);
      repeat (10) @(posedge clk); // no credit comes back, so nothing more may issue.
      check_eq("issued requests", 96'(`MEM_CREDITS), 96'(issued_cnt));
   endtask

   task automatic test_credit_return();
      int base;
      cur_test <= "test_credit_return";
      for (int k = 0; k < `MEM_CREDITS; k++) begin
         base = issued_cnt;
         grant_responses(1);
         while (issued_cnt < base + 1) @(posedge clk);
         repeat (8) @(posedge clk);
         check_eq("issued after one credit", 96'(base + 1), 96'(issued_cnt));
      end
   endtask

   task automatic test_predecode_order();
      int first;
      cur_test <= "test_predecode_order";
      first = branch_cnt;
      pop_mode <= 1;
      grant_responses(24);
      wait_drained();
      check_true(branch_cnt > first, "no control-transfer packet reached decode");
   endtask

   task automatic test_backpressure();
      cur_test <= "test_backpressure";
      pop_mode <= 0;
      grant_responses(resp_q_entries + 4);
      while (mem_resp_ready) @(posedge clk);
      check_eq("queued packets", 96'(resp_q_entries), 96'(exp_left));
      repeat (5) @(posedge clk);
      check_true(!mem_resp_ready && mem_resp_valid, "memory did not hold its response");
      pop_mode <= 1;
      wait_drained();
      // no redirect has happened yet, so every granted response must reach decode once.
      check_eq("decoded packets", 96'(resp_granted), 96'(popped_cnt));
   endtask

   task automatic test_redirect();
      int stale_before;
      cur_test <= "test_redirect";
      pop_mode <= 0;
      stale_before = stale_cnt;
      grant_responses(2);
      while (xfer_cnt < resp_granted) @(posedge clk);
      check_true(dec_valid, "no packet was waiting before the redirect");
      redirect_valid <= 1'b1;
      redirect_pc    <= 32'h0000_1000;
      @(posedge clk);
      redirect_valid <= 1'b0;
      @(posedge clk);
      check_true(!dec_valid, "dec_valid stayed high after the redirect");
      pop_mode <= 1;
      grant_responses(8); // the first answers belong to the old epoch.
      wait_drained();
      check_true(stale_cnt > stale_before, "no old-epoch response came back after the redirect");
   endtask

   task automatic test_random_mix();
      int start;
      cur_test <= "test_random_mix";
      pop_mode <= 2;
      delay_en <= 1'b1;
      for (int r = 0; r < 6; r++) begin
         start = xfer_cnt;
         grant_responses(20);
         if (r % 2 == 1) begin
            while (xfer_cnt < start + 6) @(posedge clk);
            redirect_valid <= 1'b1;
            redirect_pc    <= 32'h0000_2000 + 32'(r * 256);
            @(posedge clk);
            redirect_valid <= 1'b0;
         end
         wait_drained(); // old responses are gone before the next redirect.
      end
   endtask

   initial begin
      test_reset();
      test_credit_return();
      test_predecode_order();
      test_backpressure();
      test_redirect();
      test_random_mix();
      repeat (2) @(posedge clk);
      $display("errors: %0d, requests issued: %0d, packets decoded: %0d",
               err_cnt, issued_cnt, popped_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
fetch_pkg.sv
reg_file_1w1r.sv
fifo_fwft.sv
pc_sequencer.sv
credit_sender.sv
predecode.sv
fetch_unit_top.sv
tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the fetch unit testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_fetch_unit -o tb_fetch_unit
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/tb_fetch_unit > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q 'All tests passed!' "$log"; then
   exit 0
fi
echo "pass message not found in $log"
exit 1
